//--- list.f
verilog/ex_pkg.sv
verilog/div_if.sv
verilog/int_alu.sv
verilog/iter_divider.sv
verilog/ex_sequencer.sv
verilog/ex_stage.sv
tests/ex_stage_sva.sv
tests/ex_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module ex_stage_tb -f list.f -o ex_stage_sim

./obj_dir/ex_stage_sim | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

echo "simulation finished without failures"

//--- tests/ex_stage_tb.sv
`default_nettype none

module ex_stage_tb
	import ex_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int alu_rand = 20;
	localparam int div_rand = 10;
	localparam int resp_limit = 100;	// cycles per item
	localparam int test_items = 19 * (alu_rand + 4) + 3 + 8 * (div_rand + 2) + 8 + 4 + 4 + 1;

	logic clk;
	logic reset;
	logic in_valid, in_ready;
	addr_t pc;
	inst_t inst;
	logic branch, mem_write, wb_sel, reg_write;
	alu_op_t alu_op;
	xlen_t store_data, src_a, src_b;
	reg_idx_t rd;
	branch_imm_t branch_imm;
	logic out_ready, out_valid;
	addr_t out_pc;
	inst_t out_inst;
	logic out_mem_write, out_wb_sel, out_reg_write;
	xlen_t out_store_data, out_result;
	reg_idx_t out_rd;
	logic branch_taken, bubble;
	addr_t branch_target;

	integer seed;
	int errors;
	int tests_run;

	ex_stage UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (test_items * 70) @(posedge clk);
		$display("watchdog expired, the DUT stopped responding");
		$display("test failed");
		$finish;
	end

	function automatic xlen_t sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic xlen_t rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic xlen_t alu_model(input alu_op_t op, input xlen_t a, input xlen_t b);
		xlen_t flip;
		flip = 64'h8000_0000_0000_0000;	// signed compare as offset unsigned
		case (op)
			op_add: return a + b;
			op_addw: return sext32(32'(a + b));
			op_sll: return a << b[5:0];
			op_sllw: return sext32(32'(a << b[4:0]));
			op_sra: return $signed(a) >>> b[5:0];
			op_sraw: return sext32(32'($signed(sext32(a[31:0])) >>> b[4:0]));
			op_srl: return a >> b[5:0];
			op_srlw: return sext32(32'({32'b0, a[31:0]} >> b[4:0]));
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_slt: return ((a ^ flip) < (b ^ flip)) ? 64'd1 : 64'd0;
			op_sltu: return (a < b) ? 64'd1 : 64'd0;
			op_eq: return (a == b) ? 64'd1 : 64'd0;
			op_ne: return (a != b) ? 64'd1 : 64'd0;
			op_sge: return ((a ^ flip) >= (b ^ flip)) ? 64'd1 : 64'd0;
			op_sgeu: return (a >= b) ? 64'd1 : 64'd0;
			op_sub: return a - b;
			op_subw: return sext32(32'(a - b));
			default: return '0;
		endcase
	endfunction

	function automatic xlen_t div_model(input alu_op_t op, input xlen_t a, input xlen_t b);
		logic sgn;
		logic wrd;
		xlen_t x, y, q, r, min_v;
		sgn = op inside {op_div, op_divw, op_rem, op_remw};
		wrd = op inside {op_divw, op_divuw, op_remuw, op_remw};
		x = wrd ? (sgn ? sext32(a[31:0]) : {32'b0, a[31:0]}) : a;
		y = wrd ? (sgn ? sext32(b[31:0]) : {32'b0, b[31:0]}) : b;
		min_v = wrd ? sext32(32'h8000_0000) : 64'h8000_0000_0000_0000;
		if (y == '0) begin
			q = '1;
			r = x;
		end else if (sgn && x == min_v && y == '1) begin
			q = x;
			r = '0;
		end else if (sgn) begin
			q = $signed(x) / $signed(y);
			r = $signed(x) % $signed(y);	// sign follows dividend
		end else begin
			q = x / y;
			r = x % y;
		end
		if (wrd) begin
			q = sext32(q[31:0]);
			r = sext32(r[31:0]);
		end
		return (op >= op_rem) ? r : q;
	endfunction

	task automatic report_mismatch(input string name, input xlen_t expected, input xlen_t actual);
		errors++;
		$display("Fail %s: expected %h, actual %h", name, expected, actual);
	endtask

	task automatic close_test(input string name, input int start_err);
		tests_run++;
		$display("%s finished with %0d errors", name, errors - start_err);
	endtask

	// holds in_valid until the item shows up on out_valid
	task automatic issue_op(input alu_op_t op, input xlen_t a, input xlen_t b);
		int waited;
		waited = 0;
		alu_op = op;
		src_a = a;
		src_b = b;
		in_valid = 1'b1;
		@(negedge clk);
		while (!out_valid && waited < resp_limit) begin
			waited++;
			@(negedge clk);
		end
		if (!out_valid) begin
			errors++;
			$display("no result on out_valid within %0d cycles for op %0d", resp_limit, op);
		end
		in_valid = 1'b0;
	endtask

	task automatic reset_values();
		int start_err;
		start_err = errors;
		if (out_valid !== 1'b0)
			report_mismatch("reset out_valid", 64'd0, 64'(out_valid));
		if (out_result !== '0)
			report_mismatch("reset out_result", 64'd0, out_result);
		if (out_pc !== '0)
			report_mismatch("reset out_pc", 64'd0, out_pc);
		in_valid = 1'b0;
		close_test("reset_values", start_err);
	endtask

	task automatic alu_sweep();
		xlen_t edge_a[4];
		xlen_t edge_b[4];
		int unused[3];
		xlen_t a, b, expected;
		int start_err;
		start_err = errors;
		edge_a = '{64'd0, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
			64'h8000_0000_0000_0000};
		edge_b = '{64'd0, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd63};
		unused = '{19, 22, 31};
		for (int op = 0; op <= 18; op++) begin
			for (int i = 0; i < alu_rand + 4; i++) begin
				a = (i < 4) ? edge_a[i] : rand64();
				b = (i < 4) ? edge_b[i] : rand64();
				issue_op(alu_op_t'(op), a, b);
				expected = alu_model(alu_op_t'(op), a, b);
				if (out_result !== expected)
					report_mismatch($sformatf("alu op %0d", op), expected, out_result);
			end
		end
		foreach (unused[k]) begin
			issue_op(alu_op_t'(unused[k]), rand64(), rand64());
			if (out_result !== '0)
				report_mismatch($sformatf("unused op %0d", unused[k]), 64'd0, out_result);
		end
		close_test("alu_sweep", start_err);
	endtask

	task automatic divide_sweep();
		xlen_t a, b, expected;
		logic wrd;
		int start_err;
		start_err = errors;
		for (int op = op_div; op <= op_remw; op++) begin
			wrd = (op == op_divw || op == op_divuw || op == op_remuw || op == op_remw);
			for (int i = 0; i < div_rand + 2; i++) begin
				a = rand64();
				b = rand64() >> (i * 5);	// spread divisor sizes
				if (i == 0) begin
					b = '0;
				end else if (i == 1) begin
					a = wrd ? {a[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
					b = '1;
				end
				issue_op(alu_op_t'(op), a, b);
				expected = div_model(alu_op_t'(op), a, b);
				if (out_result !== expected)
					report_mismatch($sformatf("divide op %0d", op), expected, out_result);
			end
		end
		close_test("divide_sweep", start_err);
	endtask

	task automatic branch_resolution();
		xlen_t offset, expected_target;
		logic expected_taken;
		logic is_b;
		int start_err;
		start_err = errors;
		for (int i = 0; i < 8; i++) begin
			is_b = (i < 4);
			pc = rand64();
			branch_imm = branch_imm_t'($random(seed));
			src_a = rand64();
			src_b = (i % 3 == 0) ? src_a : rand64();
			alu_op = (i % 2 == 0) ? op_eq : op_ne;
			inst = {25'($random(seed)), is_b ? 7'b1100011 : 7'b0110011};	// B-type or R-type
			branch = (i < 6);
			in_valid = 1'b1;
			offset = {{52{branch_imm[12]}}, branch_imm};
			expected_target = pc + offset * 2;
			if (!branch)
				expected_taken = 1'b0;
			else
				expected_taken = (alu_op == op_eq) ? (src_a == src_b) : (src_a != src_b);
			@(negedge clk);
			if (branch_taken !== expected_taken)
				report_mismatch("branch_taken", 64'(expected_taken), 64'(branch_taken));
			if (branch_target !== expected_target)
				report_mismatch("branch_target", expected_target, branch_target);
			if (bubble !== is_b)
				report_mismatch("bubble on transfer", 64'(is_b), 64'(bubble));
			in_valid = 1'b0;
			@(negedge clk);
			if (bubble !== 1'b0)
				report_mismatch("bubble without transfer", 64'd0, 64'(bubble));
		end
		branch = 1'b0;
		close_test("branch_resolution", start_err);
	endtask

	task automatic back_pressure();
		xlen_t held, expected, a, b;
		int waited;
		int start_err;
		start_err = errors;
		issue_op(op_add, 64'd5, 64'd7);
		out_ready = 1'b0;
		a = rand64();
		b = rand64();
		alu_op = op_xor;
		src_a = a;
		src_b = b;
		in_valid = 1'b1;
		repeat (5) begin
			@(negedge clk);
			if (in_ready !== 1'b0)
				report_mismatch("stalled in_ready", 64'd0, 64'(in_ready));
			if (out_valid !== 1'b1 || out_result !== 64'd12)
				report_mismatch("stalled alu output", 64'd12, out_result);
		end
		out_ready = 1'b1;	// first item leaves, second loads
		@(negedge clk);
		if (out_valid !== 1'b1 || out_result !== (a ^ b))
			report_mismatch("released alu item", a ^ b, out_result);
		in_valid = 1'b0;
		@(negedge clk);
		if (out_valid !== 1'b0)
			report_mismatch("alu out_valid after accept", 64'd0, 64'(out_valid));

		held = out_result;
		out_ready = 1'b0;
		a = rand64();
		b = rand64() >> 20;
		alu_op = op_divu;
		src_a = a;
		src_b = b;
		in_valid = 1'b1;
		waited = 0;
		while (!UUT.div_bus.done && waited < resp_limit) begin
			@(negedge clk);
			waited++;
			if (in_ready !== 1'b0)
				report_mismatch("in_ready while dividing", 64'd0, 64'(in_ready));
		end
		if (!UUT.div_bus.done) begin
			errors++;
			$display("divider never finished while the output was stalled");
		end
		repeat (4) begin
			@(negedge clk);
			if (in_ready !== 1'b0 || out_valid !== 1'b0)
				report_mismatch("finished divide stalled", 64'd0, 64'(in_ready | out_valid));
			if (out_result !== held)
				report_mismatch("held out_result", held, out_result);
		end
		out_ready = 1'b1;
		@(negedge clk);
		expected = div_model(op_divu, a, b);
		if (out_valid !== 1'b1 || out_result !== expected)
			report_mismatch("released divide item", expected, out_result);
		in_valid = 1'b0;
		@(negedge clk);
		if (out_valid !== 1'b0)
			report_mismatch("divide out_valid after accept", 64'd0, 64'(out_valid));
		close_test("back_pressure", start_err);
	endtask

	task automatic field_passthrough();
		xlen_t a, b, expected;
		logic [2:0] ctrl;
		int start_err;
		start_err = errors;
		for (int i = 0; i < 4; i++) begin
			pc = rand64();
			inst = $random(seed);
			rd = reg_idx_t'($random(seed));
			store_data = rand64();
			ctrl = 3'($random(seed));
			{mem_write, wb_sel, reg_write} = ctrl;
			a = rand64();
			b = rand64();
			issue_op((i < 2) ? op_sub : op_remu, a, b);
			expected = (i < 2) ? alu_model(op_sub, a, b) : div_model(op_remu, a, b);
			if (out_result !== expected)
				report_mismatch("passthrough result", expected, out_result);
			if (out_pc !== pc)
				report_mismatch("out_pc", pc, out_pc);
			if (out_inst !== inst)
				report_mismatch("out_inst", 64'(inst), 64'(out_inst));
			if (out_rd !== rd)
				report_mismatch("out_rd", 64'(rd), 64'(out_rd));
			if (out_store_data !== store_data)
				report_mismatch("out_store_data", store_data, out_store_data);
			if ({out_mem_write, out_wb_sel, out_reg_write} !== ctrl)
				report_mismatch("control bits", 64'(ctrl),
					64'({out_mem_write, out_wb_sel, out_reg_write}));
		end
		close_test("field_passthrough", start_err);
	endtask

	initial begin
		seed = 32'h81e1fa39;
		errors = 0;
		tests_run = 0;
		reset = 1'b1;
		in_valid = 1'b1;	// pending transfer that reset must override
		pc = 64'h0000_0000_0000_4000;
		inst = '0;
		branch = 1'b0;
		mem_write = 1'b0;
		wb_sel = 1'b0;
		reg_write = 1'b0;
		alu_op = op_add;
		store_data = '0;
		src_a = 64'd3;
		src_b = 64'd4;
		rd = '0;
		branch_imm = '0;
		out_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reset_values();
		alu_sweep();
		divide_sweep();
		branch_resolution();
		back_pressure();
		field_passthrough();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/ex_stage_sva.sv
`default_nettype none

module ex_stage_sva
	import ex_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic div_busy,
	input logic out_ready,
	input logic out_valid,
	input addr_t out_pc,
	input inst_t out_inst,
	input logic out_mem_write,
	input logic out_wb_sel,
	input logic out_reg_write,
	input xlen_t out_store_data,
	input xlen_t out_result,
	input reg_idx_t out_rd
);

	timeunit 1ns;
	timeprecision 100ps;

	reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// a stalled item keeps every field
	stall_holds_outputs: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable({out_valid, out_pc, out_inst, out_mem_write,
			out_wb_sel, out_reg_write, out_store_data, out_result, out_rd}))
		else $error("out_ signals changed while the output was stalled");

	busy_blocks_input: assert property (@(posedge clk) disable iff (reset)
		div_busy |-> !in_ready)
		else $error("in_ready high while the divider is busy");

endmodule

bind ex_stage ex_stage_sva stage_checks (
	.clk            (clk),
	.reset          (reset),
	.in_ready       (in_ready),
	.div_busy       (div_bus.busy),
	.out_ready      (out_ready),
	.out_valid      (out_valid),
	.out_pc         (out_pc),
	.out_inst       (out_inst),
	.out_mem_write  (out_mem_write),
	.out_wb_sel     (out_wb_sel),
	.out_reg_write  (out_reg_write),
	.out_store_data (out_store_data),
	.out_result     (out_result),
	.out_rd         (out_rd)
);

`default_nettype wire

//--- verilog/ex_stage.sv
`default_nettype none

module ex_stage
	import ex_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  addr_t pc,
	input  inst_t inst,
	input  logic branch,
	input  logic mem_write,
	input  logic wb_sel,
	input  logic reg_write,
	input  alu_op_t alu_op,
	input  xlen_t store_data,
	input  xlen_t src_a,
	input  xlen_t src_b,
	input  reg_idx_t rd,
	input  branch_imm_t branch_imm,
	input  logic out_ready,
	output logic out_valid,
	output addr_t out_pc,
	output inst_t out_inst,
	output logic out_mem_write,
	output logic out_wb_sel,
	output logic out_reg_write,
	output xlen_t out_store_data,
	output xlen_t out_result,
	output reg_idx_t out_rd,
	output logic branch_taken,
	output addr_t branch_target,
	output logic bubble
);

	xlen_t alu_result;

	div_if div_bus ();

	int_alu u_alu (
		.alu_op     (alu_op),
		.src_a      (src_a),
		.src_b      (src_b),
		.alu_result (alu_result)
	);

	iter_divider u_div (
		.clk   (clk),
		.reset (reset),
		.div   (div_bus.divider)
	);

	ex_sequencer u_seq (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.pc             (pc),
		.inst           (inst),
		.branch         (branch),
		.mem_write      (mem_write),
		.wb_sel         (wb_sel),
		.reg_write      (reg_write),
		.alu_op         (alu_op),
		.store_data     (store_data),
		.src_a          (src_a),
		.src_b          (src_b),
		.rd             (rd),
		.branch_imm     (branch_imm),
		.out_ready      (out_ready),
		.out_valid      (out_valid),
		.out_pc         (out_pc),
		.out_inst       (out_inst),
		.out_mem_write  (out_mem_write),
		.out_wb_sel     (out_wb_sel),
		.out_reg_write  (out_reg_write),
		.out_store_data (out_store_data),
		.out_result     (out_result),
		.out_rd         (out_rd),
		.branch_taken   (branch_taken),
		.branch_target  (branch_target),
		.bubble         (bubble),
		.div            (div_bus.sequencer),
		.alu_result     (alu_result)
	);

endmodule

`default_nettype wire

//--- verilog/ex_sequencer.sv
`default_nettype none

module ex_sequencer
	import ex_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  addr_t pc,
	input  inst_t inst,
	input  logic branch,
	input  logic mem_write,
	input  logic wb_sel,
	input  logic reg_write,
	input  alu_op_t alu_op,
	input  xlen_t store_data,
	input  xlen_t src_a,
	input  xlen_t src_b,
	input  reg_idx_t rd,
	input  branch_imm_t branch_imm,
	input  logic out_ready,
	output logic out_valid,
	output addr_t out_pc,
	output inst_t out_inst,
	output logic out_mem_write,
	output logic out_wb_sel,
	output logic out_reg_write,
	output xlen_t out_store_data,
	output xlen_t out_result,
	output reg_idx_t out_rd,
	output logic branch_taken,
	output addr_t branch_target,
	output logic bubble,
	div_if.sequencer div,
	input  xlen_t alu_result
);

	logic is_div;
	logic use_rem;
	logic transfer;
	xlen_t ex_result;

	assign is_div = alu_op inside {[op_div:op_remw]};
	assign use_rem = alu_op inside {[op_rem:op_remw]};
	assign div.div_signed = alu_op inside {op_div, op_divw, op_rem, op_remw};
	assign div.word = alu_op inside {op_divw, op_divuw, op_remuw, op_remw};
	assign div.dividend = src_a;
	assign div.divisor = src_b;

	// only from idle, divider trusts this
	assign div.start = in_valid & is_div & ~div.busy & ~div.done;

	assign in_ready = is_div ? (out_ready & div.done) : out_ready;
	assign transfer = in_valid & in_ready;
	assign div.accept = transfer & is_div;

	assign ex_result = !is_div ? alu_result : (use_rem ? div.rema : div.quot);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_pc <= '0;
			out_inst <= '0;
			out_mem_write <= 1'b0;
			out_wb_sel <= 1'b0;
			out_reg_write <= 1'b0;
			out_store_data <= '0;
			out_result <= '0;
			out_rd <= '0;
		end else if (out_ready) begin
			out_valid <= transfer;	// drops once taken
			out_pc <= pc;
			out_inst <= inst;
			out_mem_write <= mem_write;
			out_wb_sel <= wb_sel;
			out_reg_write <= reg_write;
			out_store_data <= store_data;
			out_result <= ex_result;
			out_rd <= rd;
		end
	end

	assign branch_taken = branch & (alu_result != '0);
	assign branch_target = pc + {{(xlen - 13){branch_imm[12]}}, branch_imm, 1'b0};
	assign bubble = (inst[6:0] == opcode_branch) & transfer;

endmodule

`default_nettype wire

//--- verilog/iter_divider.sv
`default_nettype none

module iter_divider
	import ex_pkg::*;
(
	input  logic clk,
	input  logic reset,
	div_if.divider div
);

	localparam int cnt_w = $clog2(xlen + 1);

	div_state_t state;
	logic [cnt_w-1:0] count;

	xlen_t a_ext;
	xlen_t b_ext;
	logic a_neg;
	logic b_neg;
	xlen_t a_abs;
	xlen_t b_abs;

	xlen_t divisor_r;
	xlen_t dividend_r;	// kept for the divide by zero case
	xlen_t rem_r;
	xlen_t quo_r;		// shifts out dividend, shifts in quotient
	logic neg_q;
	logic neg_r;
	logic zero_r;
	logic word_r;

	logic [xlen:0] rem_shift;
	logic [xlen:0] trial;
	xlen_t q_fix;
	xlen_t r_fix;

	// word ops use the low half, extended per signedness
	always_comb begin
		a_ext = div.dividend;
		b_ext = div.divisor;
		if (div.word) begin
			if (div.div_signed) begin
				a_ext = sext_w(div.dividend[word_len-1:0]);
				b_ext = sext_w(div.divisor[word_len-1:0]);
			end else begin
				a_ext = xlen_t'(div.dividend[word_len-1:0]);
				b_ext = xlen_t'(div.divisor[word_len-1:0]);
			end
		end
	end

	assign a_neg = div.div_signed & a_ext[xlen-1];
	assign b_neg = div.div_signed & b_ext[xlen-1];
	assign a_abs = a_neg ? -a_ext : a_ext;
	assign b_abs = b_neg ? -b_ext : b_ext;

	assign rem_shift = {rem_r, quo_r[xlen-1]};
	assign trial = rem_shift - {1'b0, divisor_r};

	// most negative / -1 needs no special path: the unsigned quotient
	// 2^(n-1) comes back with positive sign and equals the dividend
	always_comb begin
		q_fix = neg_q ? -quo_r : quo_r;
		r_fix = neg_r ? -rem_r : rem_r;
		if (zero_r) begin
			q_fix = '1;
			r_fix = dividend_r;
		end
		if (word_r) begin
			q_fix = sext_w(q_fix[word_len-1:0]);
			r_fix = sext_w(r_fix[word_len-1:0]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end else begin
			case (state)
				idle: if (div.start) begin
					state <= run;
					count <= '0;
				end
				run: if (count == cnt_w'(xlen))
					state <= done;	// correction cycle
				else
					count <= count + 1'b1;
				done: if (div.accept)
					state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && div.start) begin
			quo_r <= a_abs;
			rem_r <= '0;
			divisor_r <= b_abs;
			dividend_r <= a_ext;
			neg_q <= a_neg ^ b_neg;
			neg_r <= a_neg;	// remainder follows dividend
			zero_r <= (b_ext == '0);
			word_r <= div.word;
		end else if (state == run) begin
			if (count == cnt_w'(xlen)) begin
				div.quot <= q_fix;
				div.rema <= r_fix;
			end else if (!trial[xlen]) begin
				rem_r <= trial[xlen-1:0];
				quo_r <= {quo_r[xlen-2:0], 1'b1};
			end else begin
				rem_r <= rem_shift[xlen-1:0];
				quo_r <= {quo_r[xlen-2:0], 1'b0};
			end
		end
	end

	assign div.busy = (state == run);
	assign div.done = (state == done);

endmodule

`default_nettype wire

//--- verilog/int_alu.sv
`default_nettype none

module int_alu
	import ex_pkg::*;
(
	input  alu_op_t alu_op,
	input  xlen_t src_a,
	input  xlen_t src_b,
	output xlen_t alu_result
);

	logic [word_len-1:0] w_res;
	logic [5:0] sh;
	logic [4:0] sh_w;

	assign sh = src_b[5:0];
	assign sh_w = src_b[4:0];

	always_comb begin
		w_res = '0;
		alu_result = '0;	// unused codes give zero
		case (alu_op)
			op_add: alu_result = src_a + src_b;
			op_addw: begin
				w_res = src_a[word_len-1:0] + src_b[word_len-1:0];
				alu_result = sext_w(w_res);
			end
			op_sll: alu_result = src_a << sh;
			op_sllw: begin
				w_res = src_a[word_len-1:0] << sh_w;
				alu_result = sext_w(w_res);
			end
			op_sra: alu_result = $signed(src_a) >>> sh;
			op_sraw: begin
				w_res = $signed(src_a[word_len-1:0]) >>> sh_w;
				alu_result = sext_w(w_res);
			end
			op_srl: alu_result = src_a >> sh;
			op_srlw: begin
				w_res = src_a[word_len-1:0] >> sh_w;
				alu_result = sext_w(w_res);
			end
			op_and: alu_result = src_a & src_b;
			op_or: alu_result = src_a | src_b;
			op_xor: alu_result = src_a ^ src_b;
			op_slt: alu_result = xlen_t'($signed(src_a) < $signed(src_b));
			op_sltu: alu_result = xlen_t'(src_a < src_b);
			op_eq: alu_result = xlen_t'(src_a == src_b);
			op_ne: alu_result = xlen_t'(src_a != src_b);
			op_sge: alu_result = xlen_t'($signed(src_a) >= $signed(src_b));
			op_sgeu: alu_result = xlen_t'(src_a >= src_b);
			op_sub: alu_result = src_a - src_b;
			op_subw: begin
				w_res = src_a[word_len-1:0] - src_b[word_len-1:0];
				alu_result = sext_w(w_res);
			end
			default: alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/div_if.sv
`default_nettype none

interface div_if
	import ex_pkg::*;
();

	logic start;		// one cycle pulse
	logic div_signed;
	logic word;
	xlen_t dividend;
	xlen_t divisor;
	logic accept;		// result taken
	logic busy;
	logic done;		// held until accept
	xlen_t quot;
	xlen_t rema;

	modport sequencer (
		output start, div_signed, word, dividend, divisor, accept,
		input busy, done, quot, rema
	);

	modport divider (
		input start, div_signed, word, dividend, divisor, accept,
		output busy, done, quot, rema
	);

	modport monitor (
		input start, div_signed, word, dividend, divisor, accept,
		input busy, done, quot, rema
	);

endinterface

`default_nettype wire

//--- verilog/ex_pkg.sv
`default_nettype none

package ex_pkg;

	localparam int xlen = 64;
	localparam int word_len = 32;

	typedef logic [xlen-1:0] xlen_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [4:0] alu_op_t;
	typedef logic [12:1] branch_imm_t;	// offset bits 12..1

	localparam alu_op_t op_add   = 5'd0;
	localparam alu_op_t op_addw  = 5'd1;
	localparam alu_op_t op_sll   = 5'd2;
	localparam alu_op_t op_sllw  = 5'd3;
	localparam alu_op_t op_sra   = 5'd4;
	localparam alu_op_t op_sraw  = 5'd5;
	localparam alu_op_t op_srl   = 5'd6;
	localparam alu_op_t op_srlw  = 5'd7;
	localparam alu_op_t op_and   = 5'd8;
	localparam alu_op_t op_or    = 5'd9;
	localparam alu_op_t op_xor   = 5'd10;
	localparam alu_op_t op_slt   = 5'd11;
	localparam alu_op_t op_sltu  = 5'd12;
	localparam alu_op_t op_eq    = 5'd13;
	localparam alu_op_t op_ne    = 5'd14;
	localparam alu_op_t op_sge   = 5'd15;
	localparam alu_op_t op_sgeu  = 5'd16;
	localparam alu_op_t op_sub   = 5'd17;
	localparam alu_op_t op_subw  = 5'd18;
	localparam alu_op_t op_div   = 5'd23;
	localparam alu_op_t op_divu  = 5'd24;
	localparam alu_op_t op_divw  = 5'd25;
	localparam alu_op_t op_divuw = 5'd26;
	localparam alu_op_t op_rem   = 5'd27;
	localparam alu_op_t op_remu  = 5'd28;
	localparam alu_op_t op_remuw = 5'd29;
	localparam alu_op_t op_remw  = 5'd30;

	localparam logic [6:0] opcode_branch = 7'b1100011;	// B-type

	typedef enum logic [1:0] {
		idle,
		run,
		done
	} div_state_t;

	// word results are sign extended from bit 31
	function automatic xlen_t sext_w(input logic [word_len-1:0] v);
		return {{(xlen - word_len){v[word_len-1]}}, v};
	endfunction

endpackage

`default_nettype wire
